// File: controlUnit.f
+incdir+dv
rtl/controlPkg.sv
rtl/instrDecoder.sv
rtl/stateSequencer.sv
rtl/controlWordGen.sv
rtl/controlUnit.sv
dv/controlUnitTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= controlUnitTb
RTL_TOP ?= controlUnit
FILELIST ?= controlUnit.f
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= TEST OK

RTL_SRCS = $(filter rtl/%,$(shell cat $(FILELIST)))
SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(shell cat $(FILELIST) | grep -v '^+') dv/instrTable.svh $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/instrTable.svh
`ifndef INSTR_TABLE_SVH
`define INSTR_TABLE_SVH

// each row holds name, opcode, funct, cycles from Fetch1 to Fetch1
// and the regWrite, pcWrite and aluOutWrite pulse counts

localparam int numRows = 19;

typedef struct {
	string name;
	logic [opcodeWidth-1:0] opcode;
	logic [functWidth-1:0] funct;
	int cycles;
	int regWrites;
	int pcWrites;
	int aluOutWrites;
} rowT;

rowT rows[numRows];

task automatic setRow(input int idx, input string name, input logic [opcodeWidth-1:0] op,
		input logic [functWidth-1:0] fn, input int cycles, input int regWrites,
		input int pcWrites, input int aluOutWrites);
	rows[idx].name = name;
	rows[idx].opcode = op;
	rows[idx].funct = fn;
	rows[idx].cycles = cycles;
	rows[idx].regWrites = regWrites;
	rows[idx].pcWrites = pcWrites;
	rows[idx].aluOutWrites = aluOutWrites;
endtask

// pcWrite pulses once in fetch and once more for a jump
// aluOutWrite pulses once in decode and once more for add family and immediates
task automatic loadTable();
	setRow(0, "add", OpArit, FunctAdd, baseCycles + 3, 1, 1, 2);
	setRow(1, "sub", OpArit, FunctSub, baseCycles + 3, 1, 1, 2);
	setRow(2, "and", OpArit, FunctAnd, baseCycles + 3, 1, 1, 2);
	setRow(3, "slt", OpArit, FunctSlt, baseCycles + 2, 1, 1, 1);
	setRow(4, "sll", OpArit, FunctSll, baseCycles + 3, 1, 1, 1);
	setRow(5, "srl", OpArit, FunctSrl, baseCycles + 3, 1, 1, 1);
	setRow(6, "sra", OpArit, FunctSra, baseCycles + 3, 1, 1, 1);
	setRow(7, "sllv", OpArit, FunctSllv, baseCycles + 3, 1, 1, 1);
	setRow(8, "srav", OpArit, FunctSrav, baseCycles + 3, 1, 1, 1);
	setRow(9, "addi", OpAddi, 6'h00, baseCycles + 3, 1, 1, 2);
	setRow(10, "addiu", OpAddiu, 6'h00, baseCycles + 3, 1, 1, 2);
	setRow(11, "j", OpJ, 6'h00, baseCycles + 1, 0, 2, 1);
	setRow(12, "jal", OpJal, 6'h00, baseCycles + 1, 1, 2, 1); // link write
	setRow(13, "jr", OpArit, FunctJr, baseCycles + 1, 0, 2, 1);
	setRow(14, "break", OpArit, FunctBreak, baseCycles + 2, 0, 2, 1);
	setRow(15, "rte", OpArit, FunctRte, baseCycles + 1, 0, 2, 1);
	setRow(16, "xchg", OpArit, FunctXchg, baseCycles + 3, 2, 1, 1); // rs and rt
	setRow(17, "illegal opcode", 6'h3f, 6'h00, baseCycles, 0, 1, 1);
	setRow(18, "illegal funct", OpArit, 6'h3f, baseCycles, 0, 1, 1);
endtask

`endif

// File: dv/controlUnitTb.sv
module controlUnitTb
	import controlPkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clkPeriod = 20;
	localparam int resetCycles = 16;
	localparam int memWaitCycles = 2;
	localparam int fetchLen = 2 + memWaitCycles;
	localparam int baseCycles = fetchLen + 3 + 1; // fetch, decode, dispatch
	localparam int longestInstr = baseCycles + 3;
	localparam int cycleLimit = longestInstr + 4;
	localparam logic [31:0] seed = 32'h0541_ca4b;

	logic clk = 1'b0;
	logic reset;
	logic [opcodeWidth-1:0] opcode;
	logic [functWidth-1:0] funct;
	stateT state;
	logic pcWrite, irWrite, aWrite, bWrite, regWrite, aluOutWrite, epcWrite;
	aluSrcAT aluSrcA;
	aluSrcBT aluSrcB;
	shiftSrcT shiftSrc;
	shiftAmtT shiftAmt;
	regDstT regDst;
	pcSourceT pcSource;
	aluOpT aluOp;
	shiftOpT shiftOp;
	dataSrcT dataSrc;

	int errorCount = 0;
	int checkCount = 0;
	int regCount, pcCount, aluCount;
	int order[];

	`include "instrTable.svh"

	localparam int watchdogCycles = resetCycles + 2 + 2 * numRows * longestInstr + 50;

	controlUnit #(
		.memWaitCycles(memWaitCycles)
	) dut0 (
		.clk(clk), .reset(reset), .opcode(opcode), .funct(funct), .state(state),
		.pcWrite(pcWrite), .irWrite(irWrite), .aWrite(aWrite), .bWrite(bWrite),
		.regWrite(regWrite), .aluOutWrite(aluOutWrite), .epcWrite(epcWrite),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .shiftSrc(shiftSrc), .shiftAmt(shiftAmt),
		.regDst(regDst), .pcSource(pcSource), .aluOp(aluOp), .shiftOp(shiftOp),
		.dataSrc(dataSrc)
	);

	always #(clkPeriod / 2) clk = ~clk;

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("** Error at time %0t: %s is %0d, expected %0d", $time, name, actual,
				expected);
		end
	endtask

	// per-cycle strobe checks with cycleIdx counted from Fetch1
	task automatic sampleCycle(input int cycleIdx);
		checkValue("irWrite", 32'(irWrite), 32'(cycleIdx < fetchLen));
		checkValue("epcWrite", 32'(epcWrite), 32'(cycleIdx == fetchLen - 1)); // Fetch2
		checkValue("aWrite", 32'(aWrite), 32'(cycleIdx == fetchLen + 2)); // Decode2
		checkValue("bWrite", 32'(bWrite), 32'(cycleIdx == fetchLen + 2));
		if (regWrite) regCount++;
		if (pcWrite) pcCount++;
		if (aluOutWrite) aluCount++;
	endtask

	// called at a falling edge in Fetch1
	task automatic runInstr(input int idx);
		int cycles;
		regCount = 0;
		pcCount = 0;
		aluCount = 0;
		sampleCycle(0);
		@(posedge clk);
		opcode <= rows[idx].opcode;
		funct <= rows[idx].funct;
		cycles = 1;
		@(negedge clk);
		while (state != Fetch1 && cycles < cycleLimit) begin
			sampleCycle(cycles);
			cycles++;
			@(negedge clk);
		end
		if (state != Fetch1) begin
			errorCount++;
			$display("%s did not return to Fetch1 within %0d cycles", rows[idx].name,
				cycleLimit);
		end else begin
			checkValue($sformatf("%s cycles", rows[idx].name), 32'(cycles),
				32'(rows[idx].cycles));
			checkValue($sformatf("%s regWrite count", rows[idx].name), 32'(regCount),
				32'(rows[idx].regWrites));
			checkValue($sformatf("%s pcWrite count", rows[idx].name), 32'(pcCount),
				32'(rows[idx].pcWrites));
			checkValue($sformatf("%s aluOutWrite count", rows[idx].name), 32'(aluCount),
				32'(rows[idx].aluOutWrites));
		end
	endtask

	task automatic shuffleOrder();
		int j;
		int tmp;
		for (int i = numRows - 1; i > 0; i--) begin
			j = int'($urandom % 32'(i + 1));
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
	endtask

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("watchdog expired after %0d cycles, sequencer stuck", watchdogCycles);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		void'($urandom(seed));
		reset = 1'b1;
		opcode = '0;
		funct = '0;
		loadTable();
		order = new[numRows];
		for (int i = 0; i < numRows; i++) order[i] = i;

		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;

		@(negedge clk); // one Idle cycle after release
		checkValue("state", 32'(state), 32'(Idle));
		checkValue("strobes", 32'({pcWrite, irWrite, aWrite, bWrite, regWrite, aluOutWrite,
			epcWrite}), 32'(0));
		checkValue("selects", 32'({aluSrcA, aluSrcB, shiftSrc, shiftAmt, regDst, pcSource,
			aluOp, shiftOp, dataSrc}), 32'(0));
		@(negedge clk);
		checkValue("state", 32'(state), 32'(Fetch1));

		for (int i = 0; i < numRows; i++) runInstr(i);
		shuffleOrder();
		for (int i = 0; i < numRows; i++) runInstr(order[i]);

		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: rtl/controlUnit.sv
module controlUnit
	import controlPkg::*;
#(
	parameter int memWaitCycles = 2
) (
	input logic clk,
	input logic reset,
	input logic [opcodeWidth-1:0] opcode,
	input logic [functWidth-1:0] funct,
	output stateT state,
	output logic pcWrite,
	output logic irWrite,
	output logic aWrite,
	output logic bWrite,
	output logic regWrite,
	output logic aluOutWrite,
	output logic epcWrite,
	output aluSrcAT aluSrcA,
	output aluSrcBT aluSrcB,
	output shiftSrcT shiftSrc,
	output shiftAmtT shiftAmt,
	output regDstT regDst,
	output pcSourceT pcSource,
	output aluOpT aluOp,
	output shiftOpT shiftOp,
	output dataSrcT dataSrc
);

	instrT instr; // sampled by the sequencer in Dispatch only

	instrDecoder decoder0 (
		.opcode(opcode),
		.funct(funct),
		.instr(instr)
	);

	stateSequencer #(
		.memWaitCycles(memWaitCycles)
	) sequencer0 (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.state(state)
	);

	controlWordGen wordGen0 (
		.state(state),
		.pcWrite(pcWrite),
		.irWrite(irWrite),
		.aWrite(aWrite),
		.bWrite(bWrite),
		.regWrite(regWrite),
		.aluOutWrite(aluOutWrite),
		.epcWrite(epcWrite),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.shiftSrc(shiftSrc),
		.shiftAmt(shiftAmt),
		.regDst(regDst),
		.pcSource(pcSource),
		.aluOp(aluOp),
		.shiftOp(shiftOp),
		.dataSrc(dataSrc)
	);

endmodule

// File: rtl/controlWordGen.sv
module controlWordGen
	import controlPkg::*;
(
	input stateT state,
	output logic pcWrite,
	output logic irWrite,
	output logic aWrite,
	output logic bWrite,
	output logic regWrite,
	output logic aluOutWrite,
	output logic epcWrite,
	output aluSrcAT aluSrcA,
	output aluSrcBT aluSrcB,
	output shiftSrcT shiftSrc,
	output shiftAmtT shiftAmt,
	output regDstT regDst,
	output pcSourceT pcSource,
	output aluOpT aluOp,
	output shiftOpT shiftOp,
	output dataSrcT dataSrc
);

	always_comb begin
		pcWrite = 1'b0;
		irWrite = 1'b0;
		aWrite = 1'b0;
		bWrite = 1'b0;
		regWrite = 1'b0;
		aluOutWrite = 1'b0;
		epcWrite = 1'b0;
		aluSrcA = AluSrcAPc;
		aluSrcB = AluSrcBRegB;
		shiftSrc = ShiftSrcRegA;
		shiftAmt = ShiftAmtRegB;
		regDst = RegDstRt;
		pcSource = PcSrcAlu;
		aluOp = AluNone;
		shiftOp = ShiftNone;
		dataSrc = DataAluOut;

		case (state)
			Fetch1, FetchWait: begin
				irWrite = 1'b1;
				aluSrcB = AluSrcBFour; // pc + 4
				aluOp = AluAdd;
			end
			Fetch2: begin
				irWrite = 1'b1;
				pcWrite = 1'b1;
				epcWrite = 1'b1;
				aluSrcB = AluSrcBFour;
				aluOp = AluAdd;
			end
			Decode1, DecodeWait: begin
				aluOutWrite = (state == DecodeWait); // latch branch target
				aluSrcB = AluSrcBImmShift;
				aluOp = AluAdd;
			end
			Decode2: begin
				aWrite = 1'b1;
				bWrite = 1'b1;
				aluSrcA = AluSrcARegA;
			end
			Add2, Sub2, And2: begin
				aluOutWrite = 1'b1;
				aluSrcA = AluSrcARegA;
				regDst = RegDstRd;
				aluOp = (state == Add2) ? AluAdd : (state == Sub2) ? AluSub : AluAnd;
			end
			AddSubAnd: regDst = RegDstRd;
			AddSubAnd2: begin
				regWrite = 1'b1;
				regDst = RegDstRd;
			end
			Addi2, Addiu2: begin
				aluOutWrite = 1'b1;
				aluSrcA = AluSrcARegA;
				aluSrcB = AluSrcBImm;
				aluOp = AluAdd;
			end
			Addi4: regWrite = 1'b1; // result to rt
			Break2: begin
				pcWrite = 1'b1;
				aluSrcB = AluSrcBFour; // pc - 4
				aluOp = AluSub;
			end
			Break3: aluOp = AluSub;
			Rte2: begin
				pcWrite = 1'b1;
				pcSource = PcSrcEpc;
			end
			Sll2, Srl2, Sra2: begin
				shiftSrc = ShiftSrcRegB;
				shiftAmt = ShiftAmtShamt;
				shiftOp = ShiftLoad;
			end
			Sllv2, Srav2: shiftOp = ShiftLoad;
			Sll3, Srl3, Sra3: begin
				shiftSrc = ShiftSrcRegB;
				shiftAmt = ShiftAmtShamt;
				regDst = RegDstRd;
				dataSrc = DataShifter;
				shiftOp = (state == Sll3) ? ShiftSll : (state == Srl3) ? ShiftSrl : ShiftSra;
			end
			Sllv3, Srav3: begin
				regDst = RegDstRd;
				dataSrc = DataShifter;
				shiftOp = (state == Sllv3) ? ShiftSll : ShiftSra;
			end
			Sll4: begin
				regWrite = 1'b1;
				regDst = RegDstRd;
				dataSrc = DataShifter;
			end
			Slt2, Slt3: begin
				regWrite = (state == Slt2);
				aluSrcA = AluSrcARegA;
				regDst = RegDstRd;
				aluOp = AluSlt;
				dataSrc = DataLessThan;
			end
			Jr2: begin
				pcWrite = 1'b1;
				aluSrcA = AluSrcARegA; // rs through the ALU
			end
			Xchg2: begin
				regWrite = 1'b1;
				aluSrcA = AluSrcARegA;
				regDst = RegDstRs;
				dataSrc = DataRegB;
			end
			Xchg3, Xchg4: begin
				regWrite = (state == Xchg3);
				aluSrcA = AluSrcARegA;
				dataSrc = DataRegA; // old rs into rt
			end
			J2, Jal2: begin
				pcWrite = 1'b1;
				pcSource = PcSrcJump;
				regWrite = (state == Jal2); // link
				regDst = (state == Jal2) ? RegDstRa : RegDstRt;
			end
			default: ; // Idle, Dispatch and Addi3/Addiu3 stay quiet
		endcase
	end

endmodule

// File: rtl/stateSequencer.sv
module stateSequencer
	import controlPkg::*;
#(
	parameter int memWaitCycles = 2
) (
	input logic clk,
	input logic reset,
	input instrT instr,
	output stateT state
);

	// at least one bit even for a single wait cycle
	localparam int countWidth = (memWaitCycles > 1) ? $clog2(memWaitCycles) : 1;

	stateT nextState;
	logic [countWidth-1:0] waitCount;
	logic waitDone;

	assign waitDone = (waitCount == countWidth'(memWaitCycles - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= Idle;
			waitCount <= '0;
		end else begin
			state <= nextState;
			if (state == FetchWait && !waitDone) begin
				waitCount <= waitCount + 1'b1;
			end else begin
				waitCount <= '0;
			end
		end
	end

	// dispatch target for each class
	function automatic stateT firstExec(input instrT cls);
		case (cls)
			InstrAdd: return Add2;
			InstrSub: return Sub2;
			InstrAnd: return And2;
			InstrSlt: return Slt2;
			InstrSll: return Sll2;
			InstrSrl: return Srl2;
			InstrSra: return Sra2;
			InstrSllv: return Sllv2;
			InstrSrav: return Srav2;
			InstrAddi: return Addi2;
			InstrAddiu: return Addiu2;
			InstrJ: return J2;
			InstrJal: return Jal2;
			InstrJr: return Jr2;
			InstrBreak: return Break2;
			InstrRte: return Rte2;
			InstrXchg: return Xchg2;
			default: return Fetch1; // illegal class goes back to fetch
		endcase
	endfunction

	always_comb begin
		nextState = Fetch1;
		case (state)
			Idle: nextState = Fetch1;
			Fetch1: nextState = FetchWait;
			FetchWait: nextState = waitDone ? Fetch2 : FetchWait; // memory latency
			Fetch2: nextState = Decode1;
			Decode1: nextState = DecodeWait;
			DecodeWait: nextState = Decode2;
			Decode2: nextState = Dispatch;
			Dispatch: nextState = firstExec(instr);

			Add2, Sub2, And2: nextState = AddSubAnd;
			AddSubAnd: nextState = AddSubAnd2;
			Addi2: nextState = Addi3;
			Addiu2: nextState = Addiu3;
			Addi3, Addiu3: nextState = Addi4;

			Sll2: nextState = Sll3;
			Sllv2: nextState = Sllv3;
			Srl2: nextState = Srl3;
			Sra2: nextState = Sra3;
			Srav2: nextState = Srav3;
			Sll3, Sllv3, Srl3, Sra3, Srav3: nextState = Sll4;

			Break2: nextState = Break3;
			Slt2: nextState = Slt3;
			Xchg2: nextState = Xchg3;
			Xchg3: nextState = Xchg4;

			// AddSubAnd2, Addi4, Sll4, Break3, Slt3, Xchg4, Rte2, Jr2, J2, Jal2
			default: nextState = Fetch1;
		endcase
	end

endmodule

// File: rtl/instrDecoder.sv
module instrDecoder
	import controlPkg::*;
(
	input logic [opcodeWidth-1:0] opcode,
	input logic [functWidth-1:0] funct,
	output instrT instr
);

	instrT rClass; // class of an R-type instruction

	always_comb begin
		case (funct)
			FunctAdd: rClass = InstrAdd;
			FunctSub: rClass = InstrSub;
			FunctAnd: rClass = InstrAnd;
			FunctSlt: rClass = InstrSlt;
			FunctSll: rClass = InstrSll;
			FunctSrl: rClass = InstrSrl;
			FunctSra: rClass = InstrSra;
			FunctSllv: rClass = InstrSllv;
			FunctSrav: rClass = InstrSrav;
			FunctJr: rClass = InstrJr;
			FunctBreak: rClass = InstrBreak;
			FunctRte: rClass = InstrRte;
			FunctXchg: rClass = InstrXchg;
			default: rClass = InstrIllegal; // unknown funct
		endcase
	end

	always_comb begin
		case (opcode)
			OpArit: instr = rClass;
			OpAddi: instr = InstrAddi;
			OpAddiu: instr = InstrAddiu;
			OpJ: instr = InstrJ;
			OpJal: instr = InstrJal;
			default: instr = InstrIllegal;
		endcase
	end

endmodule

// File: rtl/controlPkg.sv
package controlPkg;

	localparam int opcodeWidth = 6;
	localparam int functWidth = 6;

	typedef enum logic [6:0] {
		Idle, Fetch1, FetchWait, Fetch2,
		Decode1, DecodeWait, Decode2, Dispatch,
		Add2, Sub2, And2, AddSubAnd, AddSubAnd2,
		Addi2, Addi3, Addi4, Addiu2, Addiu3,
		Break2, Break3, Rte2,
		Sll2, Sll3, Sllv2, Sllv3, Srl2, Srl3,
		Sra2, Sra3, Srav2, Srav3, Sll4, // Sll4 is the common shift writeback
		Slt2, Slt3, Jr2,
		Xchg2, Xchg3, Xchg4,
		J2, Jal2
	} stateT;

	typedef enum logic [4:0] {
		InstrAdd, InstrSub, InstrAnd, InstrSlt,
		InstrSll, InstrSrl, InstrSra, InstrSllv, InstrSrav,
		InstrAddi, InstrAddiu,
		InstrJ, InstrJal, InstrJr,
		InstrBreak, InstrRte, InstrXchg,
		InstrIllegal
	} instrT;

	// opcodes
	localparam logic [opcodeWidth-1:0] OpArit = 6'b000000; // R-type decoded by funct
	localparam logic [opcodeWidth-1:0] OpAddi = 6'b001000;
	localparam logic [opcodeWidth-1:0] OpAddiu = 6'b001001;
	localparam logic [opcodeWidth-1:0] OpJ = 6'b000010;
	localparam logic [opcodeWidth-1:0] OpJal = 6'b000011;

	// R-type funct codes
	localparam logic [functWidth-1:0] FunctAdd = 6'b100000;
	localparam logic [functWidth-1:0] FunctSub = 6'b100010;
	localparam logic [functWidth-1:0] FunctAnd = 6'b100100;
	localparam logic [functWidth-1:0] FunctSlt = 6'b101010;
	localparam logic [functWidth-1:0] FunctSll = 6'b000000;
	localparam logic [functWidth-1:0] FunctSrl = 6'b000010;
	localparam logic [functWidth-1:0] FunctSra = 6'b000011;
	localparam logic [functWidth-1:0] FunctSllv = 6'b000100;
	localparam logic [functWidth-1:0] FunctSrav = 6'b000111;
	localparam logic [functWidth-1:0] FunctJr = 6'b001000;
	localparam logic [functWidth-1:0] FunctBreak = 6'b001101;
	localparam logic [functWidth-1:0] FunctRte = 6'b010011;
	localparam logic [functWidth-1:0] FunctXchg = 6'b000101;

	typedef enum logic [1:0] {AluSrcAPc = 2'b00, AluSrcARegA = 2'b01} aluSrcAT;

	typedef enum logic [1:0] {
		AluSrcBRegB = 2'b00,
		AluSrcBFour = 2'b01,
		AluSrcBImm = 2'b10,
		AluSrcBImmShift = 2'b11 // branch offset as imm << 2
	} aluSrcBT;

	typedef enum logic [1:0] {ShiftSrcRegA = 2'b00, ShiftSrcRegB = 2'b10} shiftSrcT;
	typedef enum logic [1:0] {ShiftAmtRegB = 2'b00, ShiftAmtShamt = 2'b10} shiftAmtT;

	typedef enum logic [2:0] {
		RegDstRt = 3'b000, RegDstRd = 3'b001, RegDstRa = 3'b011, RegDstRs = 3'b100
	} regDstT;

	typedef enum logic [2:0] {
		PcSrcAlu = 3'b000, PcSrcEpc = 3'b010, PcSrcJump = 3'b100
	} pcSourceT;

	typedef enum logic [2:0] {
		AluNone = 3'b000, AluAdd = 3'b001, AluSub = 3'b010, AluAnd = 3'b011, AluSlt = 3'b111
	} aluOpT;

	typedef enum logic [2:0] {
		ShiftNone = 3'b000, ShiftLoad = 3'b001, ShiftSll = 3'b010,
		ShiftSrl = 3'b011, ShiftSra = 3'b100
	} shiftOpT;

	typedef enum logic [3:0] {
		DataAluOut = 4'b0000,
		DataLessThan = 4'b0100,
		DataShifter = 4'b0101,
		DataRegA = 4'b0110,
		DataRegB = 4'b0111
	} dataSrcT;

endpackage
